// ==== project.f ====
portalPkg.sv
fifo1.sv
burstSplitter.sv
userEcho.sv
portalControl.sv
portalBridge.sv
portalBridgeTb.sv

// ==== portalBridgeTb.sv ====
`timescale 1ns/10ps

module portalBridgeTb;

  localparam int WAIT_LIMIT = 200;

  localparam portalPkg::addrT REQ_CTRL = 32'h0000_0000;
  localparam portalPkg::addrT IND_CTRL = 32'h0000_1000;
  localparam portalPkg::addrT REQ_DATA = 32'h0000_0020;

  logic              CLK;
  logic              nRST;
  portalPkg::addrT   arAddr;
  portalPkg::lenT    arLen;
  portalPkg::idT     arId;
  logic              arEna;
  logic              arRdy;
  portalPkg::addrT   awAddr;
  portalPkg::lenT    awLen;
  portalPkg::idT     awId;
  logic              awEna;
  logic              awRdy;
  portalPkg::dataT   wData;
  logic              wEna;
  logic              wRdy;
  portalPkg::dataT   rData;
  portalPkg::idT     rId;
  logic              rEna;
  logic              rRdy;
  portalPkg::idT     bId;
  logic              bEna;
  logic              bRdy;
  logic              interrupt;

  portalPkg::dataT   wordsSent [8];
  portalPkg::dataT   expectWords [16];
  portalPkg::dataT   beatData [16];
  portalPkg::idT     beatIds [16];
  int                beatCount;
  logic [31:0]       lfsrState;
  int                errorCount;
  int                errorsAtStart;
  int                testsRun;
  int                testsFailed;

  portalBridge UUT (
    .CLK(CLK), .nRST(nRST),
    .arAddr(arAddr), .arLen(arLen), .arId(arId), .arEna(arEna), .arRdy(arRdy),
    .awAddr(awAddr), .awLen(awLen), .awId(awId), .awEna(awEna), .awRdy(awRdy),
    .wData(wData), .wEna(wEna), .wRdy(wRdy),
    .rData(rData), .rId(rId), .rEna(rEna), .rRdy(rRdy),
    .bId(bId), .bEna(bEna), .bRdy(bRdy),
    .interrupt(interrupt)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reference values.
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkEqual(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkTrue(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      $display("Failure at %0t ns: %s", $time, what);
      errorCount++;
    end
  endtask

  task automatic abortOnTimeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic finishTest(input int number, input string name);
    testsRun++;
    if (errorCount == errorsAtStart) begin
      $display("Test %0d %s: ok", number, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: %0d errors", number, name, errorCount - errorsAtStart);
    end
    errorsAtStart = errorCount;
  endtask

  // Galois LFSR stepped once per bit.
  function automatic logic lfsrBit();
    logic out;
    out       = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (out) begin
      lfsrState = lfsrState ^ 32'hd000_0001;
    end
    return out;
  endfunction

  function automatic portalPkg::dataT randomWord();
    portalPkg::dataT word;
    int              b;
    word = '0;
    for (b = 0; b < 32; b++) begin
      word = {word[30:0], lfsrBit()};
    end
    return word;
  endfunction

  // Control page contents by offset. Select is set for the indication portal.
  function automatic portalPkg::dataT expectedCtrl(input portalPkg::offsetT offset,
                                                   input logic select, input logic pending);
    case (offset)
      5'd0, 5'd12: return select ? 32'd0 : {31'd0, pending};
      5'd8:        return 32'd1;
      5'd16:       return select ? 32'd6 : 32'd5;
      5'd20:       return 32'd2;
      default:     return 32'd0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks.
  ////////////////////////////////////////////////////////////////////////////

  task automatic readBurst(input portalPkg::addrT addr, input portalPkg::lenT len,
                           input portalPkg::idT id, input int stall);
    int              waitCount;
    int              holdCycle;
    portalPkg::dataT heldData;
    portalPkg::idT   heldId;
    beatCount = 0;
    rRdy      = (stall == 0);
    arAddr    = addr;
    arLen     = len;
    arId      = id;
    arEna     = 1'b1;
    waitCount = 0;
    while (!arRdy) begin
      @(negedge CLK);
      waitCount++;
      if (waitCount > WAIT_LIMIT) abortOnTimeout("arRdy stayed low");
    end
    @(negedge CLK);
    arEna     = 1'b0;
    waitCount = 0;
    while (beatCount <= int'(len)) begin
      if (rEna) begin
        if (!rRdy) begin
          heldData = rData;
          heldId   = rId;
          for (holdCycle = 0; holdCycle < stall; holdCycle++) begin
            @(negedge CLK);
            checkTrue("rEna dropped while rRdy was low", rEna);
            checkEqual("rData", rData, heldData);
            checkEqual("rId", 32'(rId), 32'(heldId));
          end
          rRdy = 1'b1;
        end
        // The beat transfers on the next rising edge.
        beatData[beatCount] = rData;
        beatIds[beatCount]  = rId;
        beatCount++;
        waitCount = 0;
      end
      @(negedge CLK);
      rRdy = (stall == 0);
      waitCount++;
      if (waitCount > WAIT_LIMIT) abortOnTimeout("rEna stayed low during a read burst");
    end
    rRdy = 1'b1;
    repeat (8) begin
      @(negedge CLK);
      checkTrue("rEna pulsed after the last beat of a burst", !rEna);
    end
  endtask

  task automatic checkReadBurst(input portalPkg::addrT addr, input portalPkg::lenT len,
                                input portalPkg::idT id, input int stall);
    int i;
    readBurst(addr, len, id, stall);
    for (i = 0; i <= int'(len); i++) begin
      checkEqual("rData", beatData[i], expectWords[i]);
      checkEqual("rId", 32'(beatIds[i]), 32'(id));
    end
  endtask

  task automatic sendWrite(input portalPkg::addrT addr, input portalPkg::idT id,
                           input portalPkg::dataT data);
    int waitCount;
    awAddr    = addr;
    awLen     = 4'd0;
    awId      = id;
    awEna     = 1'b1;
    waitCount = 0;
    while (!awRdy) begin
      @(negedge CLK);
      waitCount++;
      if (waitCount > WAIT_LIMIT) abortOnTimeout("awRdy stayed low");
    end
    @(negedge CLK);
    awEna     = 1'b0;
    wData     = data;
    wEna      = 1'b1;
    waitCount = 0;
    while (!wRdy) begin
      @(negedge CLK);
      waitCount++;
      if (waitCount > WAIT_LIMIT) abortOnTimeout("wRdy stayed low");
    end
    @(negedge CLK);
    wEna = 1'b0;
  endtask

  task automatic awaitWriteResponse(input portalPkg::idT id);
    int waitCount;
    bRdy      = 1'b1;
    waitCount = 0;
    while (!bEna) begin
      @(negedge CLK);
      waitCount++;
      if (waitCount > WAIT_LIMIT) abortOnTimeout("bEna never rose for a write burst");
    end
    checkEqual("bId", 32'(bId), 32'(id));
    @(negedge CLK);
    checkTrue("bEna stayed high after one response", !bEna);
  endtask

  task automatic writeBurst(input portalPkg::addrT addr, input portalPkg::idT id,
                            input portalPkg::dataT data);
    sendWrite(addr, id, data);
    awaitWriteResponse(id);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    errorCount    = 0;
    errorsAtStart = 0;
    testsRun      = 0;
    testsFailed   = 0;
    lfsrState     = 32'hfe41_1071;
    nRST          = 1'b0;
    arAddr        = '0;
    arLen         = '0;
    arId          = '0;
    arEna         = 1'b0;
    awAddr        = '0;
    awLen         = '0;
    awId          = '0;
    awEna         = 1'b0;
    wData         = '0;
    wEna          = 1'b0;
    rRdy          = 1'b1;
    bRdy          = 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);

    checkEqual("arRdy", 32'(arRdy), 32'd1);
    checkEqual("awRdy", 32'(awRdy), 32'd1);
    checkEqual("wRdy", 32'(wRdy), 32'd1);
    checkEqual("rEna", 32'(rEna), 32'd0);
    checkEqual("bEna", 32'(bEna), 32'd0);
    checkEqual("interrupt", 32'(interrupt), 32'd0);
    finishTest(1, "reset values");

    for (i = 0; i < 6; i++) begin
      expectWords[i] = expectedCtrl(5'(4 * i), 1'b1, 1'b0);
    end
    checkReadBurst(IND_CTRL, 4'd5, 6'd3, 0);
    for (i = 0; i < 6; i++) begin
      expectWords[i] = expectedCtrl(5'(4 * i), 1'b0, 1'b0);
    end
    checkReadBurst(REQ_CTRL, 4'd5, 6'd4, 0);
    finishTest(2, "control page reads");

    for (i = 0; i < 3; i++) begin
      wordsSent[i] = randomWord();
      writeBurst(REQ_DATA, 6'(10 + i), wordsSent[i]);
    end
    for (i = 0; i < 3; i++) begin
      expectWords[0] = wordsSent[i];
      checkReadBurst(REQ_DATA, 4'd0, 6'(20 + i), 0);
    end
    // Empty queue reads back as zero.
    expectWords[0] = 32'd0;
    checkReadBurst(REQ_DATA, 4'd0, 6'd23, 0);
    finishTest(3, "data page echo");

    writeBurst(REQ_CTRL + 32'd4, 6'd30, 32'd1);
    checkEqual("interrupt", 32'(interrupt), 32'd0);
    wordsSent[0] = randomWord();
    writeBurst(REQ_DATA, 6'd31, wordsSent[0]);
    checkEqual("interrupt", 32'(interrupt), 32'd1);
    // A waiting word shows up in the request portal's status words.
    for (i = 0; i < 4; i++) begin
      expectWords[i] = expectedCtrl(5'(4 * i), 1'b0, 1'b1);
    end
    checkReadBurst(REQ_CTRL, 4'd3, 6'd36, 0);
    expectWords[0] = wordsSent[0];
    checkReadBurst(REQ_DATA, 4'd0, 6'd32, 0);
    checkEqual("interrupt", 32'(interrupt), 32'd0);
    writeBurst(REQ_CTRL + 32'd4, 6'd33, 32'd0);
    wordsSent[0] = randomWord();
    writeBurst(REQ_DATA, 6'd34, wordsSent[0]);
    checkEqual("interrupt", 32'(interrupt), 32'd0);
    expectWords[0] = wordsSent[0];
    checkReadBurst(REQ_DATA, 4'd0, 6'd35, 0);
    finishTest(4, "interrupt enable");

    for (i = 0; i < 4; i++) begin
      wordsSent[i] = randomWord();
      writeBurst(REQ_DATA, 6'(40 + i), wordsSent[i]);
    end
    expectWords[0] = 32'd0;
    checkReadBurst(REQ_DATA + 32'd4, 4'd0, 6'd44, 0);
    // Hold the response so it waits for the check below.
    bRdy         = 1'b0;
    wordsSent[4] = randomWord();
    sendWrite(REQ_DATA, 6'd45, wordsSent[4]);
    repeat (16) begin
      @(negedge CLK);
      checkTrue("bEna rose while the echo queue was full", !bEna);
    end
    expectWords[0] = wordsSent[0];
    checkReadBurst(REQ_DATA, 4'd0, 6'd46, 0);
    awaitWriteResponse(6'd45);
    for (i = 1; i < 5; i++) begin
      expectWords[0] = wordsSent[i];
      checkReadBurst(REQ_DATA, 4'd0, 6'(46 + i), 0);
    end
    finishTest(5, "full queue backpressure");

    for (i = 0; i < 4; i++) begin
      expectWords[i] = expectedCtrl(5'(8 + 4 * i), 1'b1, 1'b0);
    end
    checkReadBurst(IND_CTRL + 32'd8, 4'd3, 6'd50, 5);
    finishTest(6, "read stall");

    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== portalBridge.sv ====
`timescale 1ns/10ps

module portalBridge (
  input  logic            CLK,
  input  logic            nRST,
  input  portalPkg::addrT arAddr,
  input  portalPkg::lenT  arLen,
  input  portalPkg::idT   arId,
  input  logic            arEna,
  output logic            arRdy,
  input  portalPkg::addrT awAddr,
  input  portalPkg::lenT  awLen,
  input  portalPkg::idT   awId,
  input  logic            awEna,
  output logic            awRdy,
  input  portalPkg::dataT wData,
  input  logic            wEna,
  output logic            wRdy,
  output portalPkg::dataT rData,
  output portalPkg::idT   rId,
  output logic            rEna,
  input  logic            rRdy,
  output portalPkg::idT   bId,
  output logic            bEna,
  input  logic            bRdy,
  output logic            interrupt
);

  portalPkg::beatT     readBeatIn;
  portalPkg::beatT     readBeatOut;
  logic                readBeatEnq;
  logic                readBeatEnqRdy;
  logic                readBeatValid;
  logic                readPop;
  logic                readDataEnqRdy;
  portalPkg::readRespT readResp;
  portalPkg::readRespT readRespOut;
  portalPkg::dataT     readValue;

  portalPkg::beatT     writeBeatIn;
  portalPkg::beatT     writeBeatOut;
  logic                writeBeatEnq;
  logic                writeBeatEnqRdy;
  logic                writeBeatValid;
  logic                writeDataValid;
  portalPkg::dataT     writeWord;
  logic                writeDoneEnqRdy;
  logic                writeHold;
  logic                writePop;

  logic                popEna;
  logic                popValid;
  portalPkg::dataT     popData;
  logic                pushEna;
  logic                pushRdy;

  ////////////////////////////////////////////////////////////////////////////
  // Read path.
  ////////////////////////////////////////////////////////////////////////////

  burstSplitter readSplit (
    .CLK(CLK), .nRST(nRST),
    .reqEna(arEna), .reqOffset(arAddr[4:0]), .reqLen(arLen), .reqId(arId), .reqRdy(arRdy),
    .beatEna(readBeatEnq), .beat(readBeatIn), .beatRdy(readBeatEnqRdy)
  );

  fifo1 #(.WIDTH($bits(portalPkg::beatT))) readBeat (
    .CLK(CLK), .nRST(nRST),
    .enqEna(readBeatEnq), .enqData(readBeatIn), .enqRdy(readBeatEnqRdy),
    .deqEna(readPop), .deqRdy(readBeatValid), .first(readBeatOut)
  );

  // A read beat moves only when the response stage has room.
  assign readPop       = readBeatValid && readDataEnqRdy;
  assign readResp.data = readValue;
  assign readResp.id   = readBeatOut.id;

  fifo1 #(.WIDTH($bits(portalPkg::readRespT))) readData (
    .CLK(CLK), .nRST(nRST),
    .enqEna(readPop), .enqData(readResp), .enqRdy(readDataEnqRdy),
    .deqEna(rEna && rRdy), .deqRdy(rEna), .first(readRespOut)
  );

  assign rData = readRespOut.data;
  assign rId   = readRespOut.id;

  ////////////////////////////////////////////////////////////////////////////
  // Write path.
  ////////////////////////////////////////////////////////////////////////////

  burstSplitter writeSplit (
    .CLK(CLK), .nRST(nRST),
    .reqEna(awEna), .reqOffset(awAddr[4:0]), .reqLen(awLen), .reqId(awId), .reqRdy(awRdy),
    .beatEna(writeBeatEnq), .beat(writeBeatIn), .beatRdy(writeBeatEnqRdy)
  );

  fifo1 #(.WIDTH($bits(portalPkg::beatT))) writeBeat (
    .CLK(CLK), .nRST(nRST),
    .enqEna(writeBeatEnq), .enqData(writeBeatIn), .enqRdy(writeBeatEnqRdy),
    .deqEna(writePop), .deqRdy(writeBeatValid), .first(writeBeatOut)
  );

  fifo1 #(.WIDTH($bits(portalPkg::dataT))) writeData (
    .CLK(CLK), .nRST(nRST),
    .enqEna(wEna), .enqData(wData), .enqRdy(wRdy),
    .deqEna(writePop), .deqRdy(writeDataValid), .first(writeWord)
  );

  // Beat and word pop together; the last beat also needs a response slot.
  assign writePop = writeBeatValid && writeDataValid && !writeHold
                    && (!writeBeatOut.last || writeDoneEnqRdy);

  fifo1 #(.WIDTH($bits(portalPkg::idT))) writeDone (
    .CLK(CLK), .nRST(nRST),
    .enqEna(writePop && writeBeatOut.last), .enqData(writeBeatOut.id),
    .enqRdy(writeDoneEnqRdy),
    .deqEna(bEna && bRdy), .deqRdy(bEna), .first(bId)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Control page and user block.
  ////////////////////////////////////////////////////////////////////////////

  portalControl control (
    .CLK(CLK), .nRST(nRST),
    .arCapture(arEna && arRdy), .arAddr(arAddr),
    .awCapture(awEna && awRdy), .awAddr(awAddr),
    .readBeatEna(readPop), .readOffset(readBeatOut.offset),
    .writeBeatEna(writePop), .writeOffset(writeBeatOut.offset), .writeData(writeWord),
    .popValid(popValid), .popData(popData), .pushRdy(pushRdy),
    .popEna(popEna), .pushEna(pushEna),
    .readValue(readValue), .writeHold(writeHold), .interrupt(interrupt)
  );

  userEcho user (
    .CLK(CLK), .nRST(nRST),
    .pushEna(pushEna), .pushData(writeWord), .pushRdy(pushRdy),
    .popEna(popEna), .popData(popData), .popValid(popValid)
  );

endmodule

// ==== portalControl.sv ====
`timescale 1ns/10ps

module portalControl (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              arCapture,
  input  portalPkg::addrT   arAddr,
  input  logic              awCapture,
  input  portalPkg::addrT   awAddr,
  input  logic              readBeatEna,
  input  portalPkg::offsetT readOffset,
  input  logic              writeBeatEna,
  input  portalPkg::offsetT writeOffset,
  input  portalPkg::dataT   writeData,
  input  logic              popValid,
  input  portalPkg::dataT   popData,
  input  logic              pushRdy,
  output logic              popEna,
  output logic              pushEna,
  output portalPkg::dataT   readValue,
  output logic              writeHold,
  output logic              interrupt
);

  logic            readCtrl;
  logic            readSelect;
  logic            writeCtrl;
  logic            writeSelect;
  logic            intEnable;
  logic            intrStatus;
  logic            writeToUser;
  portalPkg::dataT ctrlValue;
  portalPkg::dataT dataValue;

  ////////////////////////////////////////////////////////////////////////////
  // Page flags and interrupt enable.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      readCtrl    <= 1'b0;
      readSelect  <= 1'b0;
      writeCtrl   <= 1'b0;
      writeSelect <= 1'b0;
      intEnable   <= 1'b0;
    end else begin
      if (arCapture) begin
        readCtrl   <= (arAddr[portalPkg::CTRL_PAGE_HI:portalPkg::CTRL_PAGE_LO] == '0);
        readSelect <= arAddr[portalPkg::PAGE_SELECT_BIT];
      end
      if (awCapture) begin
        writeCtrl   <= (awAddr[portalPkg::CTRL_PAGE_HI:portalPkg::CTRL_PAGE_LO] == '0);
        writeSelect <= awAddr[portalPkg::PAGE_SELECT_BIT];
      end
      if (writeBeatEna && writeCtrl && writeOffset == portalPkg::OFF_STATUS) begin
        intEnable <= writeData[0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read data.
  ////////////////////////////////////////////////////////////////////////////

  // Only the request portal reports pending indications.
  assign intrStatus = popValid && !readSelect;

  always_comb begin
    case (readOffset)
      portalPkg::OFF_DATA:   ctrlValue = {31'd0, intrStatus};
      portalPkg::OFF_ID:     ctrlValue = 32'd1;
      portalPkg::OFF_INTR:   ctrlValue = {31'd0, intrStatus};
      portalPkg::OFF_PORTAL: ctrlValue = readSelect ? portalPkg::PORTAL_ID_IND
                                                    : portalPkg::PORTAL_ID_REQ;
      portalPkg::OFF_TOP:    ctrlValue = portalPkg::TOP_COUNT;
      default:               ctrlValue = '0;
    endcase
  end

  always_comb begin
    case (readOffset)
      portalPkg::OFF_DATA:   dataValue = popValid ? popData : '0;
      portalPkg::OFF_STATUS: dataValue = {31'd0, pushRdy};
      default:               dataValue = '0;
    endcase
  end

  assign readValue = readCtrl ? ctrlValue : dataValue;
  assign popEna    = readBeatEna && !readCtrl && readOffset == portalPkg::OFF_DATA && popValid;

  // Data page writes to the indication portal are simply dropped.
  assign writeToUser = !writeCtrl && !writeSelect;
  assign pushEna     = writeBeatEna && writeToUser;
  assign writeHold   = writeToUser && !pushRdy;

  assign interrupt = popValid && intEnable;

endmodule

// ==== userEcho.sv ====
`timescale 1ns/10ps

module userEcho (
  input  logic            CLK,
  input  logic            nRST,
  input  logic            pushEna,
  input  portalPkg::dataT pushData,
  output logic            pushRdy,
  input  logic            popEna,
  output portalPkg::dataT popData,
  output logic            popValid
);

  localparam int ECHO_DEPTH = 4;
  localparam int PTR_W      = $clog2(ECHO_DEPTH);
  localparam int CNT_W      = $clog2(ECHO_DEPTH + 1);

  portalPkg::dataT  mem [ECHO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPush;
  logic             doPop;

  assign pushRdy  = (count != CNT_W'(ECHO_DEPTH));
  assign popValid = (count != '0);
  assign popData  = mem[rdPtr];

  assign doPush = pushEna && pushRdy;
  assign doPop  = popEna && popValid;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone.
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

endmodule

// ==== burstSplitter.sv ====
`timescale 1ns/10ps

module burstSplitter (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              reqEna,
  input  portalPkg::offsetT reqOffset,
  input  portalPkg::lenT    reqLen,
  input  portalPkg::idT     reqId,
  output logic              reqRdy,
  output logic              beatEna,
  output portalPkg::beatT   beat,
  input  logic              beatRdy
);

  portalPkg::burstReqT reqIn;
  portalPkg::burstReqT req;
  logic                reqValid;
  logic                reqRelease;

  // Position inside the burst after the first beat.
  logic                notFirst;
  portalPkg::offsetT   curOffset;
  portalPkg::countT    curCount;

  portalPkg::offsetT   nextOffset;
  portalPkg::countT    nextCount;
  logic                lastNext;

  assign reqIn.offset = reqOffset;
  assign reqIn.count  = portalPkg::countT'(reqLen) + 5'd1;
  assign reqIn.id     = reqId;

  fifo1 #(
    .WIDTH($bits(portalPkg::burstReqT))
  ) reqStage (
    .CLK(CLK),
    .nRST(nRST),
    .enqEna(reqEna),
    .enqData(reqIn),
    .enqRdy(reqRdy),
    .deqEna(reqRelease),
    .deqRdy(reqValid),
    .first(req)
  );

  assign nextOffset = notFirst ? curOffset : req.offset;
  assign nextCount  = notFirst ? curCount : req.count;
  assign lastNext   = (nextCount == 5'd1);

  assign beatEna    = reqValid && beatRdy;
  assign reqRelease = beatEna && lastNext;

  assign beat.offset = nextOffset;
  assign beat.id     = req.id;
  assign beat.last   = lastNext;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      notFirst  <= 1'b0;
      curOffset <= '0;
      curCount  <= '0;
    end else if (beatEna) begin
      // Offset wraps inside the page window.
      curOffset <= nextOffset + 5'd4;
      curCount  <= nextCount - 5'd1;
      notFirst  <= !lastNext;
    end
  end

endmodule

// ==== fifo1.sv ====
`timescale 1ns/10ps

module fifo1 #(
  parameter int WIDTH = 32
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             enqEna,
  input  logic [WIDTH-1:0] enqData,
  output logic             enqRdy,
  input  logic             deqEna,
  output logic             deqRdy,
  output logic [WIDTH-1:0] first
);

  logic             full;
  logic [WIDTH-1:0] store;

  // Only one side can be ready at a time.
  assign enqRdy = !full;
  assign deqRdy = full;
  assign first  = store;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (enqEna && !full) begin
      full <= 1'b1;
    end else if (deqEna && full) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (enqEna && !full) begin
      store <= enqData;
    end
  end

endmodule

// ==== portalPkg.sv ====
package portalPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus field widths.
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] dataT;
  typedef logic [31:0] addrT;

  // Byte offset of a word inside a 32-byte page window.
  typedef logic [4:0] offsetT;

  // Burst length minus one as carried on the bus.
  typedef logic [3:0] lenT;

  // Between 1 and 16 beats still to go.
  typedef logic [4:0] countT;

  typedef logic [5:0] idT;

  ////////////////////////////////////////////////////////////////////////////
  // Grouped payloads.
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    offsetT offset;
    countT  count;
    idT     id;
  } burstReqT;

  typedef struct packed {
    offsetT offset;
    idT     id;
    logic   last;
  } beatT;

  typedef struct packed {
    dataT data;
    idT   id;
  } readRespT;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode and page layout.
  ////////////////////////////////////////////////////////////////////////////

  // Set selects the indication portal.
  localparam int PAGE_SELECT_BIT = 12;

  // All zero in this field means the control page.
  localparam int CTRL_PAGE_LO = 5;
  localparam int CTRL_PAGE_HI = 11;

  localparam offsetT OFF_DATA   = 5'd0;
  localparam offsetT OFF_STATUS = 5'd4;
  localparam offsetT OFF_ID     = 5'd8;
  localparam offsetT OFF_INTR   = 5'd12;
  localparam offsetT OFF_PORTAL = 5'd16;
  localparam offsetT OFF_TOP    = 5'd20;

  localparam dataT PORTAL_ID_REQ = 32'd5;
  localparam dataT PORTAL_ID_IND = 32'd6;
  localparam dataT TOP_COUNT     = 32'd2;

endpackage
